// ==== files.f ====
hw/uartcon_pkg.sv
hw/uartcon_tx_fifo.sv
hw/uartcon_tx.sv
hw/uartcon_rx.sv
hw/uartcon.sv
testbench/tb_uartcon.sv

// ==== Makefile ====
# Verilator build and run for the uartcon testbench.

SRCS := $(wildcard hw/*.sv) $(wildcard testbench/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes.
obj_dir/Vtb_uartcon: files.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_uartcon -f files.f -o Vtb_uartcon

# pass or fail comes from the log.
run: obj_dir/Vtb_uartcon
	./obj_dir/Vtb_uartcon | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/tb_uartcon.sv ====
`timescale 1ns/1ps

module tb_uartcon;
   import uartcon_pkg::*;

   localparam int FRAME_W  = UC_DATA_BITS + 2;   // start, data, stop.
   localparam int WAIT_MAX = 2000;               // clocks per wait.

   logic                    clk;
   logic                    rst_n;
   logic                    tx_wr;
   logic [UC_DATA_BITS-1:0] tx_wdata;
   logic                    tx_full;
   logic                    txd;
   logic                    rxd;
   logic                    rx_valid;
   logic [UC_DATA_BITS-1:0] rx_data;
   logic                    rx_frame_err;
   logic                    loopback;
   logic                    line_rxd;

   logic [UC_DATA_BITS-1:0] exp_q [$];
   integer                  seed;
   int                      error_count = 0;
   int                      timeout_count = 0;
   int                      rx_count = 0;
   int                      err_count = 0;
   int                      sent_count = 0;
   int                      exp_err_count = 0;
   logic                    saw_full = 1'b0;

   uartcon UUT (
      .clk          (clk),
      .rst_n        (rst_n),
      .tx_wr        (tx_wr),
      .tx_wdata     (tx_wdata),
      .tx_full      (tx_full),
      .txd          (txd),
      .rxd          (rxd),
      .rx_valid     (rx_valid),
      .rx_data      (rx_data),
      .rx_frame_err (rx_frame_err)
   );

   assign rxd = loopback ? txd : line_rxd;   // serial loop or driven line.

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // bytes come back in the order they were written.
   function automatic logic [UC_DATA_BITS-1:0] expected_byte();
      return exp_q.pop_front();
   endfunction

   function automatic logic [FRAME_W-1:0] frame_bits(input logic [UC_DATA_BITS-1:0] b);
      return {1'b1, b, 1'b0};   // bit 0 goes first.
   endfunction

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string msg);
      if (actual !== expected) begin
         error_count++;
         $display("** Error at %0t: %s: got %0h, expected %0h", $time, msg, actual, expected);
      end
   endtask

   // compare process.
   always @(posedge clk) begin
      if (rst_n) begin
         if (tx_full) begin
            saw_full = 1'b1;
         end
         if (rx_valid) begin
            rx_count++;
            if (exp_q.size() == 0) begin
               error_count++;
               $display("rx_valid at %0t with no byte outstanding", $time);
            end else begin
               check_value(32'(rx_data), 32'(expected_byte()), "rx_data");
            end
         end
         if (rx_frame_err) begin
            err_count++;
         end
      end
   end

   task automatic wait_rx_count(input int target, input string what);
      int n;
      n = 0;
      while (rx_count < target && n < WAIT_MAX) begin
         @(negedge clk);
         n++;
      end
      if (rx_count < target) begin
         timeout_count++;
         $display("timeout: no byte received for %s", what);
      end
   endtask

   task automatic wait_err_count(input int target, input string what);
      int n;
      n = 0;
      while (err_count < target && n < WAIT_MAX) begin
         @(negedge clk);
         n++;
      end
      if (err_count < target) begin
         timeout_count++;
         $display("timeout: no framing error reported for %s", what);
      end
   endtask

   task automatic write_byte(input logic [UC_DATA_BITS-1:0] b);
      int n;
      n = 0;
      @(negedge clk);
      while (tx_full && n < WAIT_MAX) begin
         @(negedge clk);
         n++;
      end
      if (tx_full) begin
         timeout_count++;
         $display("timeout: transmit FIFO never left full");
      end else begin
         @(posedge clk);
         tx_wr    <= 1'b1;
         tx_wdata <= b;
         exp_q.push_back(b);
         sent_count++;
         @(posedge clk);
         tx_wr    <= 1'b0;
      end
   endtask

   // samples txd near each bit centre, starting at the start edge.
   task automatic check_txd_frame(input logic [UC_DATA_BITS-1:0] b);
      logic [FRAME_W-1:0] bits;
      int                 n;
      bits = frame_bits(b);
      n = 0;
      @(negedge clk);
      while (txd && n < WAIT_MAX) begin
         @(negedge clk);
         n++;
      end
      if (txd) begin
         timeout_count++;
         $display("timeout: txd never showed a start bit");
      end else begin
         @(negedge clk);
         for (int i = 0; i < FRAME_W; i++) begin
            check_value(32'(txd), 32'(bits[i]), "txd frame bit");
            repeat (UC_BIT_CLKS) @(negedge clk);
         end
      end
   endtask

   task automatic drive_line_frame(input logic [FRAME_W-1:0] bits);
      for (int i = 0; i < FRAME_W; i++) begin
         @(posedge clk);
         line_rxd <= bits[i];
         repeat (UC_BIT_CLKS - 1) @(posedge clk);
      end
      @(posedge clk);
      line_rxd <= 1'b1;
      repeat (2 * UC_BIT_CLKS) @(posedge clk);   // idle gap.
   endtask

   initial begin
      logic [UC_DATA_BITS-1:0] b;
      seed     = 4442;
      rst_n    = 1'b0;
      tx_wr    = 1'b0;
      tx_wdata = '0;
      loopback = 1'b1;
      line_rxd = 1'b1;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_value(32'(txd), 32'd1, "txd after reset");
      check_value(32'(tx_full), 32'd0, "tx_full after reset");
      check_value(32'(rx_valid), 32'd0, "rx_valid after reset");
      check_value(32'(rx_frame_err), 32'd0, "rx_frame_err after reset");

      // single bytes through the loop.
      for (int k = 0; k < 4; k++) begin
         b = 8'($random(seed));
         write_byte(b);
         check_txd_frame(b);
         wait_rx_count(sent_count, "single loopback byte");
      end

      for (int k = 0; k < 20; k++) begin
         write_byte(8'($random(seed)));
      end
      wait_rx_count(sent_count, "burst");
      check_value(32'(saw_full), 32'd1, "tx_full seen during burst");

      @(posedge clk);
      loopback <= 1'b0;
      for (int k = 0; k < 4; k++) begin
         b = 8'($random(seed));
         exp_q.push_back(b);
         sent_count++;
         drive_line_frame(frame_bits(b));
         wait_rx_count(sent_count, "line byte");
      end

      // stop bit held low.
      for (int k = 0; k < 3; k++) begin
         b = 8'($random(seed));
         exp_err_count++;
         drive_line_frame({1'b0, b, 1'b0});
         wait_err_count(exp_err_count, "bad stop bit");
      end
      check_value(rx_count, sent_count, "rx_valid count after bad frames");

      @(posedge clk);
      line_rxd <= 1'b0;
      @(posedge clk);
      line_rxd <= 1'b1;   // one clock low.
      repeat ((FRAME_W + 2) * UC_BIT_CLKS) @(negedge clk);   // past a whole frame.
      check_value(rx_count, sent_count, "rx_valid count after glitch");
      check_value(err_count, exp_err_count, "framing errors after glitch");

      b = 8'($random(seed));
      exp_q.push_back(b);
      sent_count++;
      drive_line_frame(frame_bits(b));
      wait_rx_count(sent_count, "line byte after glitch");

      check_value(32'(exp_q.size()), 32'd0, "bytes still outstanding");
      check_value(err_count, exp_err_count, "framing error count");
      $display("errors: %0d mismatches, %0d timeouts", error_count, timeout_count);
      if (error_count == 0 && timeout_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== hw/uartcon.sv ====
`timescale 1ns/1ps

module uartcon (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic                                 tx_wr,
   input  logic [uartcon_pkg::UC_DATA_BITS-1:0] tx_wdata,
   output logic                                 tx_full,
   output logic                                 txd,
   input  logic                                 rxd,
   output logic                                 rx_valid,
   output logic [uartcon_pkg::UC_DATA_BITS-1:0] rx_data,
   output logic                                 rx_frame_err
);

   logic                                 fifo_valid;
   logic [uartcon_pkg::UC_DATA_BITS-1:0] fifo_data;
   logic                                 tx_load;

   // transmit queue.
   uartcon_tx_fifo u_tx_fifo (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr_en   (tx_wr),
      .wr_data (tx_wdata),
      .full    (tx_full),
      .valid   (fifo_valid),
      .data    (fifo_data),
      .load    (tx_load)
   );

   // serializer, pops the fifo with load.
   uartcon_tx u_tx (
      .rst_n (rst_n),
      .clk   (clk),
      .txd   (txd),
      .valid (fifo_valid),
      .load  (tx_load),
      .data  (fifo_data)
   );

   uartcon_rx u_rx (
      .rst_n        (rst_n),
      .clk          (clk),
      .rxd          (rxd),
      .rx_valid     (rx_valid),
      .rx_data      (rx_data),
      .rx_frame_err (rx_frame_err)
   );

endmodule

// ==== hw/uartcon_rx.sv ====
`timescale 1ns/1ps

module uartcon_rx (
   input  logic                                 rst_n,
   input  logic                                 clk,
   input  logic                                 rxd,
   output logic                                 rx_valid,
   output logic [uartcon_pkg::UC_DATA_BITS-1:0] rx_data,
   output logic                                 rx_frame_err
);
   import uartcon_pkg::*;

   logic                    rxd_meta;
   logic                    rxd_sync;
   logic                    rxd_prev;
   logic                    start_edge;
   logic [UC_SAMPLE_W-1:0]  sample_count;
   logic [UC_BIT_W-1:0]     bit_count;
   logic                    mid_point;
   logic [UC_STATE_W-1:0]   state;
   logic [UC_DATA_BITS-1:0] shift_reg;

   // two-flop synchronizer plus one flop for edge detect.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
         rxd_prev <= 1'b1;
      end else begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
         rxd_prev <= rxd_sync;
      end
   end

   assign start_edge = rxd_prev && !rxd_sync;
   assign mid_point  = (sample_count == UC_MID_SAMPLE);   // bit centre.

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sample_count <= '0;
         bit_count    <= '0;
      end else begin
         if (state != R_IDLE) begin
            sample_count <= sample_count + 1'b1;   // free running per bit.
         end else begin
            sample_count <= '0;
         end
         if (state == R_DATA) begin
            if (mid_point) begin
               bit_count <= bit_count + 1'b1;
            end
         end else begin
            bit_count <= '0;
         end
      end
   end

   // lsb arrives first, so shift in from the top.
   always_ff @(posedge clk) begin
      if (state == R_DATA && mid_point) begin
         shift_reg <= {rxd_sync, shift_reg[UC_DATA_BITS-1:1]};
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state        <= R_IDLE;
         rx_valid     <= 1'b0;
         rx_data      <= '0;
         rx_frame_err <= 1'b0;
      end else begin
         rx_valid     <= 1'b0;
         rx_frame_err <= 1'b0;
         case (state)
            R_IDLE: begin
               if (start_edge) begin
                  state <= R_START;
               end
            end
            R_START: begin
               if (mid_point) begin
                  if (rxd_sync) begin
                     state <= R_IDLE;   // glitch.
                  end else begin
                     state <= R_DATA;
                  end
               end
            end
            R_DATA: begin
               if (mid_point && bit_count == UC_LAST_BIT) begin
                  state <= R_STOP;
               end
            end
            R_STOP: begin
               if (mid_point) begin
                  state <= R_IDLE;
                  if (rxd_sync) begin
                     rx_valid <= 1'b1;
                     rx_data  <= shift_reg;
                  end else begin
                     rx_frame_err <= 1'b1;   // stop bit low.
                  end
               end
            end
            default: begin
               state <= R_IDLE;
            end
         endcase
      end
   end

   a_valid_xor_err: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(rx_valid && rx_frame_err)
   ) else $error("rx_valid and rx_frame_err together");

   a_valid_pulse: assert property (
      @(posedge clk) disable iff (!rst_n)
      rx_valid |=> !rx_valid
   ) else $error("rx_valid longer than one cycle");

   a_err_pulse: assert property (
      @(posedge clk) disable iff (!rst_n)
      rx_frame_err |=> !rx_frame_err
   ) else $error("rx_frame_err longer than one cycle");

endmodule

// ==== hw/uartcon_tx.sv ====
`timescale 1ns/1ps

module uartcon_tx (
   input  logic                                 rst_n,
   input  logic                                 clk,
   output logic                                 txd,
   input  logic                                 valid,
   output logic                                 load,
   input  logic [uartcon_pkg::UC_DATA_BITS-1:0] data
);
   import uartcon_pkg::*;

   logic [UC_SAMPLE_W-1:0]  sample_count;
   logic [UC_BIT_W-1:0]     bit_count;
   logic [UC_DATA_BITS-1:0] tx_data;
   logic                    sample_point;
   logic [UC_STATE_W-1:0]   state;
   logic                    out_data;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sample_count <= '0;
         bit_count    <= '0;
      end else begin
         if (state != S_IDLE) begin
            sample_count <= sample_count + 1'b1;
         end else begin
            sample_count <= '0;
         end
         if (state == S_DATA) begin
            if (sample_point) begin
               bit_count <= bit_count + 1'b1;
            end
         end else begin
            bit_count <= '0;
         end
      end
   end

   assign sample_point = (sample_count == UC_LAST_SAMPLE);   // last clock of a bit.

   // byte capture and lsb-first shift.
   always_ff @(posedge clk) begin
      if (state == S_IDLE && valid) begin
         tx_data <= data;
      end else if (state == S_DATA && sample_point) begin
         tx_data <= {1'b0, tx_data[UC_DATA_BITS-1:1]};
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= S_IDLE;
         load     <= 1'b0;
         out_data <= 1'b1;
      end else begin
         case (state)
            S_IDLE: begin
               if (valid) begin
                  state <= S_START;
                  load  <= 1'b1;   // pops the fifo next edge.
               end
            end
            S_START: begin
               load     <= 1'b0;
               out_data <= 1'b0;
               if (sample_point) begin
                  state <= S_DATA;
               end
            end
            S_DATA: begin
               out_data <= tx_data[0];
               if (sample_point && bit_count == UC_LAST_BIT) begin
                  state <= S_STOP;
               end
            end
            S_STOP: begin
               out_data <= 1'b1;
               if (sample_point) begin
                  state <= S_LAST;
               end
            end
            S_LAST: begin
               out_data <= 1'b1;
               if (sample_point) begin
                  state <= S_IDLE;
               end
            end
            default: begin
               state <= S_IDLE;
            end
         endcase
      end
   end

   assign txd = out_data;   // registered, one cycle behind state.

   a_load_pulse: assert property (
      @(posedge clk) disable iff (!rst_n)
      load |=> !load
   ) else $error("load held longer than one cycle");

endmodule

// ==== hw/uartcon_tx_fifo.sv ====
`timescale 1ns/1ps

module uartcon_tx_fifo (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic                                 wr_en,
   input  logic [uartcon_pkg::UC_DATA_BITS-1:0] wr_data,
   output logic                                 full,
   output logic                                 valid,
   output logic [uartcon_pkg::UC_DATA_BITS-1:0] data,
   input  logic                                 load
);
   import uartcon_pkg::*;

   logic [UC_DATA_BITS-1:0] mem [UC_FIFO_DEPTH];
   logic [UC_FIFO_AW-1:0]   wr_ptr;
   logic [UC_FIFO_AW-1:0]   rd_ptr;
   logic [UC_FIFO_AW:0]     count;
   logic                    push;
   logic                    pop;

   assign push = wr_en && !full;   // dropped when full.
   assign pop  = load && valid;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;   // wraps at depth.
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10: begin
               count <= count + 1'b1;
            end
            2'b01: begin
               count <= count - 1'b1;
            end
            default: begin
               count <= count;   // idle or push and pop together.
            end
         endcase
      end
   end

   assign full  = (count == (UC_FIFO_AW+1)'(UC_FIFO_DEPTH));
   assign valid = (count != '0);
   assign data  = mem[rd_ptr];   // head entry.

   a_count_bound: assert property (
      @(posedge clk) disable iff (!rst_n)
      count <= (UC_FIFO_AW+1)'(UC_FIFO_DEPTH)
   ) else $error("tx fifo count above depth");

   // transmitter must only pop an entry it was offered.
   a_no_pop_empty: assert property (
      @(posedge clk) disable iff (!rst_n)
      load |-> valid
   ) else $error("load while tx fifo empty");

endmodule

// ==== hw/uartcon_pkg.sv ====
package uartcon_pkg;

   // frame format.
   localparam int UC_DATA_BITS = 8;               // data bits per frame.
   localparam int UC_BIT_W     = $clog2(UC_DATA_BITS);

   // bit timing.
   localparam int UC_BIT_CLKS  = 4;               // clocks per bit.
   localparam int UC_SAMPLE_W  = $clog2(UC_BIT_CLKS);

   localparam logic [UC_SAMPLE_W-1:0] UC_MID_SAMPLE  = UC_SAMPLE_W'(1);
   localparam logic [UC_SAMPLE_W-1:0] UC_LAST_SAMPLE = UC_SAMPLE_W'(UC_BIT_CLKS - 1);
   localparam logic [UC_BIT_W-1:0]    UC_LAST_BIT    = UC_BIT_W'(UC_DATA_BITS - 1);

   // transmit fifo.
   localparam int UC_FIFO_DEPTH = 4;
   localparam int UC_FIFO_AW    = 2;              // pointer width.

   localparam int UC_STATE_W = 4;

   // transmitter states.
   localparam logic [UC_STATE_W-1:0] S_IDLE  = 4'd0;
   localparam logic [UC_STATE_W-1:0] S_START = 4'd1;
   localparam logic [UC_STATE_W-1:0] S_DATA  = 4'd2;
   localparam logic [UC_STATE_W-1:0] S_STOP  = 4'd3;
   localparam logic [UC_STATE_W-1:0] S_LAST  = 4'd4;  // extra idle bit.

   // receiver states.
   localparam logic [UC_STATE_W-1:0] R_IDLE  = 4'd0;
   localparam logic [UC_STATE_W-1:0] R_START = 4'd1;
   localparam logic [UC_STATE_W-1:0] R_DATA  = 4'd2;
   localparam logic [UC_STATE_W-1:0] R_STOP  = 4'd3;

endpackage
